// ==== rtl/dtcm_pkg.sv ====
// DTCM subsystem shared types
package dtcm_pkg;

  //////////////////////////////
  // Widths

  localparam int XLEN        = 32;
  localparam int DTCM_ADDR_W = 16;  // Byte address on the ICB ports

  typedef logic [XLEN-1:0]        data_t;
  typedef logic [XLEN/8-1:0]      mask_t;
  typedef logic [DTCM_ADDR_W-1:0] icb_addr_t;

  //////////////////////////////
  // ICB beats

  // One command beat
  typedef struct packed {
    logic      read;
    icb_addr_t addr;
    data_t     wdata;
    mask_t     wmask;
  } icb_cmd_t;

  // One response beat
  typedef struct packed {
    logic  err;
    data_t rdata;
  } icb_rsp_t;

  //////////////////////////////
  // Source tag and low-power states

  typedef logic src_t;

  localparam src_t SRC_LSU = 1'b0;
  localparam src_t SRC_EXT = 1'b1;

  typedef enum logic [1:0] {
    LP_ACTIVE,
    LP_IDLE,
    LP_SLEEP
  } lp_state_t;

endpackage

// ==== rtl/dtcm_icb_arbiter.sv ====
// DTCM command arbiter
`timescale 1ns/10ps

module dtcm_icb_arbiter (
  input  logic               clk,
  input  logic               rst,

  // Load-store unit command channel
  input  logic               lsu_cmd_valid,
  output logic               lsu_cmd_ready,
  input  dtcm_pkg::icb_cmd_t lsu_cmd,

  // External agent command channel
  input  logic               ext_cmd_valid,
  output logic               ext_cmd_ready,
  input  dtcm_pkg::icb_cmd_t ext_cmd,

  // Toward the SRAM controller
  output logic               arb_valid,
  input  logic               arb_ready,
  output dtcm_pkg::icb_cmd_t arb_cmd,
  output dtcm_pkg::src_t     arb_src
);

  import dtcm_pkg::*;

  logic lock_vld;  // A stalled grant is pending
  src_t lock_src;
  src_t grant;

  // External agent has priority, except that a stalled
  // command keeps its grant so arb_cmd stays stable
  always_comb begin
    if (lock_vld) begin
      grant = lock_src;
    end else if (ext_cmd_valid) begin
      grant = SRC_EXT;
    end else begin
      grant = SRC_LSU;
    end
  end

  assign arb_src   = grant;
  assign arb_valid = (grant == SRC_EXT) ? ext_cmd_valid : lsu_cmd_valid;
  assign arb_cmd   = (grant == SRC_EXT) ? ext_cmd : lsu_cmd;

  // Ready back to the winner only
  assign ext_cmd_ready = arb_ready & (grant == SRC_EXT);
  assign lsu_cmd_ready = arb_ready & (grant == SRC_LSU);

  //////////////////////////////
  // Grant lock

  always_ff @(posedge clk) begin
    if (rst) begin
      lock_vld <= 1'b0;
      lock_src <= SRC_LSU;
    end else begin
      lock_vld <= arb_valid & ~arb_ready;  // Offered but not taken
      lock_src <= grant;
    end
  end

endmodule

// ==== rtl/dtcm_sram_ctrl.sv ====
// DTCM SRAM controller
`timescale 1ns/10ps

module dtcm_sram_ctrl #(
  parameter int RAM_AW = 10
) (
  input  logic               clk,
  input  logic               rst,

  // From the arbiter
  input  logic               arb_valid,
  output logic               arb_ready,
  input  dtcm_pkg::icb_cmd_t arb_cmd,
  input  dtcm_pkg::src_t     arb_src,
  input  logic               dtcm_ls,

  // SRAM macro
  output logic               ram_cs,
  output logic               ram_we,
  output logic [RAM_AW-1:0]  ram_addr,
  output dtcm_pkg::mask_t    ram_wem,
  output dtcm_pkg::data_t    ram_din,
  input  dtcm_pkg::data_t    ram_dout,

  // Toward the response router
  output logic               st_valid,
  input  logic               st_ready,
  output dtcm_pkg::src_t     st_src,
  output dtcm_pkg::icb_rsp_t st_rsp,
  output logic               busy
);

  import dtcm_pkg::*;

  logic  accept;
  logic  out_rng;
  logic  st_valid_r;
  src_t  st_src_r;
  logic  st_read_r;
  logic  st_err_r;
  logic  hold_vld;   // Read data parked in hold_data
  data_t hold_data;
  data_t rd_data;

  //////////////////////////////
  // Accept and SRAM drive

  // Stage must be empty or draining, and no light sleep
  assign arb_ready = (~st_valid_r | st_ready) & ~dtcm_ls;
  assign accept    = arb_valid & arb_ready;

  // Any address bit above the word index is out of range
  assign out_rng = (arb_cmd.addr >> (RAM_AW + 2)) != '0;

  assign ram_cs   = accept & ~out_rng;
  assign ram_we   = ram_cs & ~arb_cmd.read;
  assign ram_addr = arb_cmd.addr[RAM_AW+1:2];  // Word address
  assign ram_wem  = arb_cmd.wmask;
  assign ram_din  = arb_cmd.wdata;

  //////////////////////////////
  // Response stage

  always_ff @(posedge clk) begin
    if (rst) begin
      st_valid_r <= 1'b0;
    end else if (accept) begin
      st_valid_r <= 1'b1;
    end else if (st_ready) begin
      st_valid_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      st_src_r  <= arb_src;
      st_read_r <= arb_cmd.read;
      st_err_r  <= out_rng;
    end
  end

  // SRAM output is only valid one cycle after the read,
  // so a stalled response keeps its own copy
  always_ff @(posedge clk) begin
    if (rst) begin
      hold_vld <= 1'b0;
    end else if (st_valid_r & st_ready) begin
      hold_vld <= 1'b0;
    end else if (st_valid_r & ~hold_vld) begin
      hold_vld <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (st_valid_r & ~st_ready & ~hold_vld) begin
      hold_data <= ram_dout;
    end
  end

  assign rd_data = hold_vld ? hold_data : ram_dout;

  assign st_valid     = st_valid_r;
  assign st_src       = st_src_r;
  assign st_rsp.err   = st_err_r;
  assign st_rsp.rdata = (st_read_r & ~st_err_r) ? rd_data : '0;  // Zero for writes
  assign busy         = st_valid_r;

endmodule

// ==== rtl/dtcm_rsp_router.sv ====
// DTCM response router
`timescale 1ns/10ps

module dtcm_rsp_router (
  input  logic               clk,
  input  logic               rst,

  // From the SRAM controller stage
  input  logic               st_valid,
  output logic               st_ready,
  input  dtcm_pkg::src_t     st_src,
  input  dtcm_pkg::icb_rsp_t st_rsp,
  output logic               queue_busy,

  // Load-store unit response channel
  output logic               lsu_rsp_valid,
  input  logic               lsu_rsp_ready,
  output dtcm_pkg::icb_rsp_t lsu_rsp,

  // External agent response channel
  output logic               ext_rsp_valid,
  input  logic               ext_rsp_ready,
  output dtcm_pkg::icb_rsp_t ext_rsp
);

  import dtcm_pkg::*;

  typedef struct packed {
    src_t     src;
    icb_rsp_t rsp;
  } rsp_ent_t;

  rsp_ent_t   q_mem [2];
  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  rsp_ent_t   head;
  logic       head_vld;
  logic       head_ready;
  logic       pop;
  logic       push;
  logic       q_pop;

  assign st_ready   = (count != 2'd2);
  assign queue_busy = (count != 2'd0);

  // Empty queue lets the stage go straight out
  assign head_vld = queue_busy | st_valid;
  assign head     = queue_busy ? q_mem[rd_ptr] : rsp_ent_t'{src: st_src, rsp: st_rsp};

  assign lsu_rsp_valid = head_vld & (head.src == SRC_LSU);
  assign ext_rsp_valid = head_vld & (head.src == SRC_EXT);
  assign lsu_rsp       = head.rsp;
  assign ext_rsp       = head.rsp;

  assign head_ready = (head.src == SRC_EXT) ? ext_rsp_ready : lsu_rsp_ready;
  assign pop        = head_vld & head_ready;

  // Bypassed beats never enter the queue
  assign push  = st_valid & st_ready & ~(~queue_busy & pop);
  assign q_pop = pop & queue_busy;

  //////////////////////////////
  // Queue state

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (q_pop) begin
        rd_ptr <= ~rd_ptr;
      end
      count <= count + {1'b0, push} - {1'b0, q_pop};
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= rsp_ent_t'{src: st_src, rsp: st_rsp};
    end
  end

endmodule

// ==== rtl/dtcm_lp_ctrl.sv ====
// DTCM light-sleep control
`timescale 1ns/10ps

module dtcm_lp_ctrl #(
  parameter int LS_IDLE_CYCLES = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic any_cmd_valid,
  input  logic busy,
  output logic dtcm_active,
  output logic dtcm_ls
);

  import dtcm_pkg::*;

  localparam int CNT_W = $clog2(LS_IDLE_CYCLES + 1);

  lp_state_t  state;
  lp_state_t  state_nxt;
  logic [CNT_W-1:0] idle_cnt;  // Idle cycles seen so far
  logic       idle;

  assign idle = ~any_cmd_valid & ~busy;

  always_comb begin
    state_nxt = state;
    case (state)
      LP_ACTIVE: if (idle) state_nxt = (LS_IDLE_CYCLES <= 1) ? LP_SLEEP : LP_IDLE;
      LP_IDLE: begin
        if (!idle) begin
          state_nxt = LP_ACTIVE;
        end else if (idle_cnt == CNT_W'(LS_IDLE_CYCLES - 1)) begin
          state_nxt = LP_SLEEP;
        end
      end
      LP_SLEEP: if (!idle) state_nxt = LP_ACTIVE;  // Wake on any request
      default: state_nxt = LP_ACTIVE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= LP_ACTIVE;
      idle_cnt <= '0;
    end else begin
      state    <= state_nxt;
      idle_cnt <= (idle && state != LP_SLEEP) ? idle_cnt + 1'b1 : '0;
    end
  end

  assign dtcm_ls     = (state == LP_SLEEP);
  assign dtcm_active = ~idle;

endmodule

// ==== rtl/dtcm_subsys.sv ====
// DTCM subsystem top
`timescale 1ns/10ps

module dtcm_subsys #(
  parameter int RAM_AW         = 10,
  parameter int LS_IDLE_CYCLES = 16
) (
  input  logic               clk,
  input  logic               rst,

  input  logic               lsu_cmd_valid,
  output logic               lsu_cmd_ready,
  input  dtcm_pkg::icb_cmd_t lsu_cmd,
  output logic               lsu_rsp_valid,
  input  logic               lsu_rsp_ready,
  output dtcm_pkg::icb_rsp_t lsu_rsp,

  input  logic               ext_cmd_valid,
  output logic               ext_cmd_ready,
  input  dtcm_pkg::icb_cmd_t ext_cmd,
  output logic               ext_rsp_valid,
  input  logic               ext_rsp_ready,
  output dtcm_pkg::icb_rsp_t ext_rsp,

  // SRAM macro sits outside
  output logic               ram_cs,
  output logic               ram_we,
  output logic [RAM_AW-1:0]  ram_addr,
  output dtcm_pkg::mask_t    ram_wem,
  output dtcm_pkg::data_t    ram_din,
  input  dtcm_pkg::data_t    ram_dout,

  output logic               dtcm_active,
  output logic               dtcm_ls
);

  import dtcm_pkg::*;

  logic     arb_valid;
  logic     arb_ready;
  icb_cmd_t arb_cmd;
  src_t     arb_src;
  logic     st_valid;
  logic     st_ready;
  src_t     st_src;
  icb_rsp_t st_rsp;
  logic     ctrl_busy;
  logic     queue_busy;

  dtcm_icb_arbiter arbiter_inst (
    .clk           (clk),
    .rst           (rst),
    .lsu_cmd_valid (lsu_cmd_valid),
    .lsu_cmd_ready (lsu_cmd_ready),
    .lsu_cmd       (lsu_cmd),
    .ext_cmd_valid (ext_cmd_valid),
    .ext_cmd_ready (ext_cmd_ready),
    .ext_cmd       (ext_cmd),
    .arb_valid     (arb_valid),
    .arb_ready     (arb_ready),
    .arb_cmd       (arb_cmd),
    .arb_src       (arb_src)
  );

  dtcm_sram_ctrl #(.RAM_AW(RAM_AW)) sram_ctrl_inst (
    .clk       (clk),
    .rst       (rst),
    .arb_valid (arb_valid),
    .arb_ready (arb_ready),
    .arb_cmd   (arb_cmd),
    .arb_src   (arb_src),
    .dtcm_ls   (dtcm_ls),
    .ram_cs    (ram_cs),
    .ram_we    (ram_we),
    .ram_addr  (ram_addr),
    .ram_wem   (ram_wem),
    .ram_din   (ram_din),
    .ram_dout  (ram_dout),
    .st_valid  (st_valid),
    .st_ready  (st_ready),
    .st_src    (st_src),
    .st_rsp    (st_rsp),
    .busy      (ctrl_busy)
  );

  dtcm_rsp_router rsp_router_inst (
    .clk           (clk),
    .rst           (rst),
    .st_valid      (st_valid),
    .st_ready      (st_ready),
    .st_src        (st_src),
    .st_rsp        (st_rsp),
    .queue_busy    (queue_busy),
    .lsu_rsp_valid (lsu_rsp_valid),
    .lsu_rsp_ready (lsu_rsp_ready),
    .lsu_rsp       (lsu_rsp),
    .ext_rsp_valid (ext_rsp_valid),
    .ext_rsp_ready (ext_rsp_ready),
    .ext_rsp       (ext_rsp)
  );

  // Busy while anything is in flight
  dtcm_lp_ctrl #(.LS_IDLE_CYCLES(LS_IDLE_CYCLES)) lp_ctrl_inst (
    .clk           (clk),
    .rst           (rst),
    .any_cmd_valid (lsu_cmd_valid | ext_cmd_valid),
    .busy          (ctrl_busy | queue_busy),
    .dtcm_active   (dtcm_active),
    .dtcm_ls       (dtcm_ls)
  );

endmodule

// ==== dv/dtcm_sram_model.sv ====
// Behavioral DTCM SRAM
`timescale 1ns/10ps

module dtcm_sram_model #(
  parameter int RAM_AW = 10
) (
  input  logic              clk,
  input  logic              cs,
  input  logic              we,
  input  logic [RAM_AW-1:0] addr,
  input  dtcm_pkg::mask_t   wem,
  input  dtcm_pkg::data_t   din,
  output dtcm_pkg::data_t   dout
);

  import dtcm_pkg::*;

  localparam int WORDS = 1 << RAM_AW;

  data_t mem [WORDS];

  // Power-up contents carry the word index in both halves
  initial begin
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = 32'hd7c3_0000 ^ {16'(i), 16'(i)};
    end
    dout = '0;
  end

  //////////////////////////////
  // Single port access

  always @(posedge clk) begin
    if (cs) begin
      if (we) begin
        for (int b = 0; b < XLEN/8; b++) begin
          if (wem[b]) begin
            mem[addr][8*b +: 8] <= din[8*b +: 8];  // Byte lane write
          end
        end
      end else begin
        dout <= mem[addr];  // Data shows up one cycle later
      end
    end
  end

endmodule

// ==== dv/tb_dtcm_subsys.sv ====
// DTCM subsystem testbench
`timescale 1ns/10ps

module tb_dtcm_subsys;

  import dtcm_pkg::*;

  localparam int RAM_AW         = 10;
  localparam int LS_IDLE_CYCLES = 16;
  localparam int RAM_WORDS      = 1 << RAM_AW;
  localparam int CLK_PERIOD     = 100;
  localparam int DRV_DLY        = 10;
  localparam int RST_CYCLES     = 10;
  localparam int SEED           = 50304;
  localparam int WAIT_LIMIT     = 200;  // Longest single wait in cycles
  localparam int TEST_BUDGET    = 40 + 40 + 40 + 40 + 400 + 100;

  // Expected response beat
  typedef struct packed {
    src_t  src;
    logic  err;
    data_t rdata;
  } exp_t;

  logic     clk;
  logic     rst;
  logic     lsu_cmd_valid;
  logic     lsu_cmd_ready;
  icb_cmd_t lsu_cmd;
  logic     lsu_rsp_valid;
  logic     lsu_rsp_ready;
  icb_rsp_t lsu_rsp;
  logic     ext_cmd_valid;
  logic     ext_cmd_ready;
  icb_cmd_t ext_cmd;
  logic     ext_rsp_valid;
  logic     ext_rsp_ready;
  icb_rsp_t ext_rsp;
  logic     ram_cs;
  logic     ram_we;
  logic [RAM_AW-1:0] ram_addr;
  mask_t    ram_wem;
  data_t    ram_din;
  data_t    ram_dout;
  logic     dtcm_active;
  logic     dtcm_ls;

  data_t    ref_mem [RAM_WORDS];  // Reference RAM image
  exp_t     exp_q [$];
  src_t     acc_log [$];          // Accepted command order
  int       inflight_nxt = 0;
  int       inflight = 0;
  int       max_inflight = 0;
  int       cs_count = 0;
  int       errors = 0;
  int       checks = 0;
  int       err_mark = 0;
  int       tests_run = 0;
  int       idle_run = 0;         // Consecutive idle cycles so far
  logic     idle_cyc = 1'b0;
  logic     burst_done = 1'b0;

  dtcm_subsys #(
    .RAM_AW         (RAM_AW),
    .LS_IDLE_CYCLES (LS_IDLE_CYCLES)
  ) dtcm_subsys_inst (
    .clk (clk), .rst (rst),
    .lsu_cmd_valid (lsu_cmd_valid), .lsu_cmd_ready (lsu_cmd_ready), .lsu_cmd (lsu_cmd),
    .lsu_rsp_valid (lsu_rsp_valid), .lsu_rsp_ready (lsu_rsp_ready), .lsu_rsp (lsu_rsp),
    .ext_cmd_valid (ext_cmd_valid), .ext_cmd_ready (ext_cmd_ready), .ext_cmd (ext_cmd),
    .ext_rsp_valid (ext_rsp_valid), .ext_rsp_ready (ext_rsp_ready), .ext_rsp (ext_rsp),
    .ram_cs (ram_cs), .ram_we (ram_we), .ram_addr (ram_addr),
    .ram_wem (ram_wem), .ram_din (ram_din), .ram_dout (ram_dout),
    .dtcm_active (dtcm_active), .dtcm_ls (dtcm_ls)
  );

  dtcm_sram_model #(.RAM_AW(RAM_AW)) sram_model_inst (
    .clk (clk), .cs (ram_cs), .we (ram_we), .addr (ram_addr),
    .wem (ram_wem), .din (ram_din), .dout (ram_dout)
  );

  //////////////////////////////
  // Helpers

  function automatic data_t fill_word(input int idx);
    return 32'hd7c3_0000 ^ {16'(idx), 16'(idx)};  // Power-up pattern of the macro
  endfunction

  function automatic logic out_of_range(input icb_addr_t addr);
    return int'(addr) >= (4 << RAM_AW);  // Beyond the DTCM byte size
  endfunction

  function automatic icb_cmd_t wr_cmd(input icb_addr_t addr, input data_t d, input mask_t m);
    icb_cmd_t c;
    c.read  = 1'b0;
    c.addr  = addr;
    c.wdata = d;
    c.wmask = m;
    return c;
  endfunction

  function automatic icb_cmd_t rd_cmd(input icb_addr_t addr);
    icb_cmd_t c;
    c.read  = 1'b1;
    c.addr  = addr;
    c.wdata = '0;
    c.wmask = '0;
    return c;
  endfunction

  task automatic note_fail(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s got 0x%0h exp 0x%0h at %0t ns", name, got, exp, $time);
    end
  endtask

  task automatic step();
    @(posedge clk);
    #DRV_DLY;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    $display("test %0d %-16s %s, %0d errors", tests_run, name,
             (errors == err_mark) ? "passed" : "failed", errors - err_mark);
    err_mark = errors;
  endtask

  //////////////////////////////
  // Scoreboard

  task automatic accept_cmd(input src_t src, input icb_cmd_t cmd);
    exp_t e;
    int   w;
    e.src   = src;
    e.err   = out_of_range(cmd.addr);
    e.rdata = '0;
    w       = int'(cmd.addr[RAM_AW+1:2]);
    if (!e.err && cmd.read) begin
      e.rdata = ref_mem[w];
    end else if (!e.err) begin
      for (int b = 0; b < XLEN/8; b++) begin
        if (cmd.wmask[b]) ref_mem[w][8*b +: 8] = cmd.wdata[8*b +: 8];
      end
    end
    exp_q.push_back(e);
    acc_log.push_back(src);
  endtask

  task automatic check_rsp(input src_t src, input icb_rsp_t rsp);
    exp_t  e;
    string port;
    port = (src == SRC_EXT) ? "ext" : "lsu";
    if (exp_q.size() == 0) begin
      note_fail({"response on ", port, " with nothing outstanding"});
      return;
    end
    e = exp_q.pop_front();
    assert (e.src == src) else note_fail({"response on ", port, " out of issue order"});
    check_val({port, "_rsp.err"}, 32'(rsp.err), 32'(e.err));
    check_val({port, "_rsp.rdata"}, rsp.rdata, e.rdata);
  endtask

  // Mid-cycle sampling, responses first since they belong to older commands
  always @(negedge clk) begin
    if (!rst) begin
      // Idle means no request and nothing in flight this cycle
      idle_cyc = !lsu_cmd_valid && !ext_cmd_valid && (exp_q.size() == 0);
      check_val("dtcm_ls", dtcm_ls, idle_run >= LS_IDLE_CYCLES);
      check_val("dtcm_active", dtcm_active, !idle_cyc);
      idle_run = idle_cyc ? idle_run + 1 : 0;
      if (lsu_rsp_valid && lsu_rsp_ready) check_rsp(SRC_LSU, lsu_rsp);
      if (ext_rsp_valid && ext_rsp_ready) check_rsp(SRC_EXT, ext_rsp);
      if (lsu_cmd_valid && lsu_cmd_ready) accept_cmd(SRC_LSU, lsu_cmd);
      if (ext_cmd_valid && ext_cmd_ready) accept_cmd(SRC_EXT, ext_cmd);
      if (ram_cs) cs_count++;
      inflight_nxt = exp_q.size();
      if (inflight_nxt > max_inflight) max_inflight = inflight_nxt;
    end else begin
      idle_run = 0;
    end
  end

  always @(posedge clk) begin
    inflight <= rst ? 0 : inflight_nxt;  // Items held during the coming cycle
  end

  //////////////////////////////
  // Protocol properties

  a_reset_quiet: assert property (@(posedge clk) rst |=>
    !lsu_rsp_valid && !ext_rsp_valid && !ram_cs && !dtcm_ls)
    else note_fail("outputs active right after reset");
  a_one_rsp: assert property (@(posedge clk) disable iff (rst)
    !(lsu_rsp_valid && ext_rsp_valid)) else note_fail("both response ports valid");
  a_one_grant: assert property (@(posedge clk) disable iff (rst)
    !(lsu_cmd_ready && ext_cmd_ready)) else note_fail("both masters granted");
  // A stalled load-store command keeps its grant
  a_ext_first: assert property (@(posedge clk) disable iff (rst)
    (lsu_cmd_valid && ext_cmd_valid && !$past(lsu_cmd_valid && !lsu_cmd_ready))
    |-> !lsu_cmd_ready) else note_fail("load-store unit won over external agent");
  a_lat_lsu: assert property (@(posedge clk) disable iff (rst)
    (lsu_cmd_valid && lsu_cmd_ready && !lsu_rsp_valid && !ext_rsp_valid) |=> lsu_rsp_valid)
    else note_fail("lsu response not one cycle after the command");
  a_lat_ext: assert property (@(posedge clk) disable iff (rst)
    (ext_cmd_valid && ext_cmd_ready && !lsu_rsp_valid && !ext_rsp_valid) |=> ext_rsp_valid)
    else note_fail("ext response not one cycle after the command");
  a_hold_lsu: assert property (@(posedge clk) disable iff (rst)
    (lsu_rsp_valid && !lsu_rsp_ready) |=> (lsu_rsp_valid && $stable(lsu_rsp)))
    else note_fail("stalled lsu response changed or dropped");
  a_hold_ext: assert property (@(posedge clk) disable iff (rst)
    (ext_rsp_valid && !ext_rsp_ready) |=> (ext_rsp_valid && $stable(ext_rsp)))
    else note_fail("stalled ext response changed or dropped");
  a_cs_lsu: assert property (@(posedge clk) disable iff (rst)
    (lsu_cmd_valid && lsu_cmd_ready) |-> (ram_cs == !out_of_range(lsu_cmd.addr)))
    else note_fail("ram_cs wrong for an lsu command");
  a_cs_ext: assert property (@(posedge clk) disable iff (rst)
    (ext_cmd_valid && ext_cmd_ready) |-> (ram_cs == !out_of_range(ext_cmd.addr)))
    else note_fail("ram_cs wrong for an ext command");
  a_capacity: assert property (@(posedge clk) disable iff (rst)
    (inflight >= 3) |-> (inflight == 3 && !lsu_cmd_ready && !ext_cmd_ready))
    else note_fail("command taken with three items in flight");
  a_ls_block: assert property (@(posedge clk) disable iff (rst)
    dtcm_ls |-> (!lsu_cmd_ready && !ext_cmd_ready))
    else note_fail("command taken during light sleep");

  //////////////////////////////
  // Stimulus

  task automatic send(input src_t src, input icb_cmd_t cmd);
    int waited;
    waited = 0;
    if (src == SRC_EXT) begin
      ext_cmd       = cmd;
      ext_cmd_valid = 1'b1;
    end else begin
      lsu_cmd       = cmd;
      lsu_cmd_valid = 1'b1;
    end
    @(negedge clk);
    while (!(src == SRC_EXT ? ext_cmd_ready : lsu_cmd_ready) && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) note_fail("command was never accepted");
    step();
    if (src == SRC_EXT) ext_cmd_valid = 1'b0;
    else lsu_cmd_valid = 1'b0;
  endtask

  task automatic wait_idle();
    int waited;
    waited = 0;
    @(posedge clk);
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    if (waited >= WAIT_LIMIT) note_fail("responses did not drain");
    #DRV_DLY;
  endtask

  task automatic send_burst(input src_t src, input int n);
    icb_cmd_t  cmd;
    icb_addr_t addr;
    for (int i = 0; i < n; i++) begin
      addr = icb_addr_t'($urandom_range(0, 7) << 2);
      if ($urandom_range(0, 9) == 0) addr = addr | 16'h4000;  // Now and then out of range
      if ($urandom_range(0, 1) == 1) cmd = rd_cmd(addr);
      else cmd = wr_cmd(addr, $urandom, mask_t'($urandom_range(1, 15)));
      send(src, cmd);
    end
  endtask

  task automatic throttle_rsp();
    int span;
    lsu_rsp_ready = 1'b0;
    ext_rsp_ready = 1'b0;
    repeat (8) step();  // Long first stall fills the queue
    while (!burst_done) begin
      lsu_rsp_ready = 1'b1;
      ext_rsp_ready = 1'b1;
      span = $urandom_range(1, 3);
      repeat (span) step();
      lsu_rsp_ready = 1'b0;
      ext_rsp_ready = 1'b0;
      span = $urandom_range(1, 5);
      repeat (span) step();
    end
    lsu_rsp_ready = 1'b1;
    ext_rsp_ready = 1'b1;
  endtask

  //////////////////////////////
  // Tests

  task automatic write_then_read();
    data_t d;
    for (int p = 0; p < 2; p++) begin
      d = $urandom;
      send(src_t'(p), wr_cmd(icb_addr_t'((3 + p) << 2), d, 4'hf));
      wait_idle();
      send(src_t'(p), rd_cmd(icb_addr_t'((3 + p) << 2)));
      wait_idle();
    end
    finish_test("write read");
  endtask

  task automatic merge_byte_mask();
    send(SRC_LSU, wr_cmd(16'h0030, $urandom, 4'hf));
    send(SRC_EXT, wr_cmd(16'h0030, $urandom, 4'b0101));
    send(SRC_LSU, wr_cmd(16'h0030, $urandom, 4'b1000));
    send(SRC_EXT, rd_cmd(16'h0030));
    wait_idle();
    finish_test("byte mask");
  endtask

  task automatic reject_out_of_range();
    int cs_mark;
    cs_mark = cs_count;
    send(SRC_LSU, wr_cmd(16'h1000 | 16'h0024, $urandom, 4'hf));  // Aliases word 9
    send(SRC_EXT, rd_cmd(16'h8000 | 16'h0024));
    wait_idle();
    check_val("ram_cs count", cs_count - cs_mark, 0);
    send(SRC_LSU, rd_cmd(16'h0024));
    wait_idle();
    finish_test("out of range");
  endtask

  task automatic arbitrate_both();
    acc_log.delete();
    fork
      send(SRC_EXT, wr_cmd(16'h0040, $urandom, 4'hf));
      send(SRC_LSU, rd_cmd(16'h0040));
    join
    wait_idle();
    check_val("first accepted src", 32'(acc_log[0]), 32'(SRC_EXT));
    check_val("second accepted src", 32'(acc_log[1]), 32'(SRC_LSU));
    finish_test("priority");
  endtask

  task automatic stress_back_pressure();
    max_inflight = 0;
    burst_done   = 1'b0;
    fork
      begin
        fork
          send_burst(SRC_LSU, 12);
          send_burst(SRC_EXT, 12);
        join
        burst_done = 1'b1;
      end
      throttle_rsp();
    join
    wait_idle();
    check_val("max in flight", max_inflight, 3);
    finish_test("back pressure");
  endtask

  task automatic enter_light_sleep();
    int cnt;
    cnt = 0;
    wait_idle();
    @(negedge clk);
    while (!dtcm_ls && cnt < 2 * LS_IDLE_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    check_val("dtcm_ls", dtcm_ls, 1'b1);
    check_val("dtcm_active", dtcm_active, 1'b0);
    step();
    send(SRC_LSU, rd_cmd(16'h001c));
    check_val("dtcm_ls", dtcm_ls, 1'b0);
    wait_idle();
    finish_test("light sleep");
  endtask

  //////////////////////////////
  // Run control

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(2 * (RST_CYCLES + TEST_BUDGET) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    rst           = 1'b1;
    lsu_cmd_valid = 1'b0;
    lsu_cmd       = '0;
    lsu_rsp_ready = 1'b1;
    ext_cmd_valid = 1'b0;
    ext_cmd       = '0;
    ext_rsp_ready = 1'b1;
    for (int i = 0; i < RAM_WORDS; i++) begin
      ref_mem[i] = fill_word(i);
    end
    repeat (RST_CYCLES) @(posedge clk);
    #DRV_DLY;
    rst = 1'b0;
    step();
    write_then_read();
    merge_byte_mask();
    reject_out_of_range();
    arbitrate_both();
    stress_back_pressure();
    enter_light_sleep();
    assert (exp_q.size() == 0) else note_fail("responses still outstanding at the end");
    $display("summary: %0d tests, %0d checks, %0d errors", tests_run, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
rtl/dtcm_pkg.sv
rtl/dtcm_icb_arbiter.sv
rtl/dtcm_sram_ctrl.sv
rtl/dtcm_rsp_router.sv
rtl/dtcm_lp_ctrl.sv
rtl/dtcm_subsys.sv
dv/dtcm_sram_model.sv
dv/tb_dtcm_subsys.sv

// ==== Bender.yml ====
package:
  name: dtcm_subsys

sources:
  - rtl/dtcm_pkg.sv
  - rtl/dtcm_icb_arbiter.sv
  - rtl/dtcm_sram_ctrl.sv
  - rtl/dtcm_rsp_router.sv
  - rtl/dtcm_lp_ctrl.sv
  - rtl/dtcm_subsys.sv
  - target: test
    files:
      - dv/dtcm_sram_model.sv
      - dv/tb_dtcm_subsys.sv
